// File: hdl/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// first fetch address out of reset
`define FETCH_RESET_PC 32'h8000_0000

// direct-mapped icache geometry
`define ICACHE_LINES 16

// words per line, also the refill burst length
`define ICACHE_LINE_WORDS 4

`endif

// File: hdl/axi_pkg.sv
package axi_pkg;

  // read address channel, travels with valid
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [7:0]  len;
  } axi_ar_t;

  // read data beat
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
    logic        last;
    logic [1:0]  resp;
  } axi_r_t;

endpackage

// File: hdl/fetch_pkg.sv
package fetch_pkg;

  // instruction handed to decode
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_out_t;

  // single-cycle redirect strobe with its target
  typedef struct packed {
    logic        strobe;
    logic [31:0] target;
  } redirect_t;

  // major opcodes looked at by the predictor, inst[6:2]
  typedef enum logic [4:0] {
    op_other  = 5'b00000,
    op_branch = 5'b11000,
    op_jal    = 5'b11011
  } rv_opcode_e;

  typedef enum logic [1:0] {
    cs_idle,
    cs_request,
    cs_refill
  } icache_state_e;

endpackage

// File: hdl/icache.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module icache
  import axi_pkg::*;
  import fetch_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        fencei,
  input  logic [31:0] addr,
  input  logic        ar_ready,
  input  axi_r_t      mem_r,
  output logic        hit,
  output logic [31:0] inst,
  output axi_ar_t     mem_ar,
  output logic        r_ready
);

  localparam int WORD_BITS = $clog2(`ICACHE_LINE_WORDS);
  localparam int INDEX_BITS = $clog2(`ICACHE_LINES);
  localparam int OFFSET_BITS = WORD_BITS + 2;
  localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS;

  logic [31:0] data_mem [`ICACHE_LINES * `ICACHE_LINE_WORDS];
  logic [TAG_BITS-1:0] tag_mem [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0] line_valid;

  icache_state_e state;
  logic [31:0] miss_addr;
  logic [WORD_BITS-1:0] beat_cnt;
  logic fence_seen;

  logic [TAG_BITS-1:0] tag;
  logic [TAG_BITS-1:0] miss_tag;
  logic [INDEX_BITS-1:0] index;
  logic [INDEX_BITS-1:0] miss_index;
  logic [WORD_BITS-1:0] word;
  logic beat_done;
  logic refill_last;

  // lookup side, from the fetch pc
  assign tag = addr[31 -: TAG_BITS];
  assign index = addr[OFFSET_BITS +: INDEX_BITS];
  assign word = addr[2 +: WORD_BITS];

  // refill side, from the latched miss address
  assign miss_tag = miss_addr[31 -: TAG_BITS];
  assign miss_index = miss_addr[OFFSET_BITS +: INDEX_BITS];

  assign hit = line_valid[index] && (tag_mem[index] == tag);
  assign inst = data_mem[{index, word}];

  // r_ready is only high in refill, so valid alone marks a beat
  assign beat_done = (state == cs_refill) && mem_r.valid;
  assign refill_last = beat_done && mem_r.last;

  assign mem_ar = '{
    valid: (state == cs_request),
    addr:  miss_addr,
    len:   8'(`ICACHE_LINE_WORDS - 1)
  };
  assign r_ready = (state == cs_refill);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= cs_idle;
      line_valid <= '0;
      fence_seen <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        cs_idle: begin
          if (!hit) begin
            state <= cs_request;
            // line gets overwritten, drop it now
            line_valid[index] <= 1'b0;
            fence_seen <= 1'b0;
          end
        end
        cs_request: begin
          if (ar_ready) begin
            state <= cs_refill;
            beat_cnt <= '0;
          end
        end
        cs_refill: begin
          if (beat_done) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (mem_r.last) begin
              state <= cs_idle;
              // a fence during refill leaves possibly stale words behind
              line_valid[miss_index] <= !fence_seen;
            end
          end
        end
        default: state <= cs_idle;
      endcase

      if (fencei) begin
        line_valid <= '0;
        if (state != cs_idle) begin
          fence_seen <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == cs_idle && !hit) begin
      miss_addr <= {addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    end
    if (beat_done) begin
      data_mem[{miss_index, beat_cnt}] <= mem_r.data;
    end
    if (refill_last) begin
      tag_mem[miss_index] <= miss_tag;
    end
  end

  ar_hold: assert property (@(posedge clock) disable iff (reset)
    mem_ar.valid && !ar_ready |=> mem_ar.valid && $stable(mem_ar));

  last_in_refill: assert property (@(posedge clock) disable iff (reset)
    mem_r.valid && mem_r.last |-> state == cs_refill);

endmodule

// File: hdl/next_pc_predict.sv
`timescale 1ns/1ps

module next_pc_predict
  import fetch_pkg::*;
(
  input  logic [31:0] pc,
  input  logic [31:0] inst,
  output logic [31:0] pred_pc
);

  rv_opcode_e opcode;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] offset;

  assign opcode = rv_opcode_e'(inst[6:2]);

  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      // backward taken, forward not taken
      op_branch: offset = inst[31] ? imm_b : 32'd4;
      op_jal:    offset = imm_j;
      default:   offset = 32'd4;
    endcase
  end

  assign pred_pc = pc + offset;

endmodule

// File: hdl/ifu.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module ifu
  import fetch_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  redirect_t   jump_redirect,
  input  redirect_t   cs_redirect,
  input  logic        out_ready,
  input  logic        hit,
  input  logic [31:0] inst,
  input  logic [31:0] pred_pc,
  output logic [31:0] fetch_pc,
  output logic        out_valid,
  output fetch_out_t  out
);

  redirect_t redirect;
  logic pending;
  logic [31:0] pending_target;
  logic out_valid_q;
  logic out_free;
  logic take_inst;

  // cs redirect has priority over jump
  assign redirect = cs_redirect.strobe ? cs_redirect : jump_redirect;

  assign out_free = !out_valid_q || out_ready;
  assign take_inst = hit && out_free && !redirect.strobe && !pending;

  // redirect kills the instruction sitting in the output register
  assign out_valid = out_valid_q && !redirect.strobe;

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_pc <= `FETCH_RESET_PC;
      out_valid_q <= 1'b0;
      pending <= 1'b0;
    end else if (redirect.strobe) begin
      out_valid_q <= 1'b0;
      // cache busy on a miss, so park the target until it is done
      pending <= !hit;
      if (hit) begin
        fetch_pc <= redirect.target;
      end
    end else if (pending) begin
      out_valid_q <= 1'b0;
      if (hit) begin
        pending <= 1'b0;
        fetch_pc <= pending_target;
      end
    end else begin
      if (out_free) begin
        out_valid_q <= hit;
      end
      if (take_inst) begin
        fetch_pc <= pred_pc;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (redirect.strobe && !hit) begin
      pending_target <= redirect.target;
    end
    if (take_inst) begin
      out <= '{pc: fetch_pc, inst: inst};
    end
  end

  pc_aligned: assert property (@(posedge clock) disable iff (reset)
    out_valid |-> out.pc[1:0] == 2'b00);

  // stalled output keeps its instruction until taken or flushed
  out_hold: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid_q && $stable(out));

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
  import axi_pkg::*;
  import fetch_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  redirect_t  jump_redirect,
  input  redirect_t  cs_redirect,
  input  logic       fencei,
  input  logic       out_ready,
  input  logic       ar_ready,
  input  axi_r_t     mem_r,
  output logic       out_valid,
  output fetch_out_t out,
  output axi_ar_t    mem_ar,
  output logic       r_ready
);

  logic [31:0] fetch_pc;
  logic [31:0] inst;
  logic [31:0] pred_pc;
  logic hit;

  ifu i_ifu (
    .clock         (clock),
    .reset         (reset),
    .jump_redirect (jump_redirect),
    .cs_redirect   (cs_redirect),
    .out_ready     (out_ready),
    .hit           (hit),
    .inst          (inst),
    .pred_pc       (pred_pc),
    .fetch_pc      (fetch_pc),
    .out_valid     (out_valid),
    .out           (out)
  );

  icache i_icache (
    .clock    (clock),
    .reset    (reset),
    .fencei   (fencei),
    .addr     (fetch_pc),
    .ar_ready (ar_ready),
    .mem_r    (mem_r),
    .hit      (hit),
    .inst     (inst),
    .mem_ar   (mem_ar),
    .r_ready  (r_ready)
  );

  next_pc_predict i_next_pc_predict (
    .pc      (fetch_pc),
    .inst    (inst),
    .pred_pc (pred_pc)
  );

endmodule

// File: test/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model
  import axi_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  axi_ar_t mem_ar,
  output logic    ar_ready,
  output axi_r_t  mem_r,
  input  logic    r_ready
);

  // 4 KB window, wraps on addr[11:2]
  logic [31:0] words [1024];

  integer seed;
  logic ar_hs;
  logic r_hs;
  logic [31:0] ar_addr_q;
  logic [7:0] ar_len_q;
  logic busy;
  logic [31:0] burst_addr;
  int burst_len;
  int beat;

  initial begin
    seed = 32'hc88f_fafd;
    ar_ready = 1'b0;
    mem_r = '0;
    busy = 1'b0;
    beat = 0;
    burst_addr = '0;
    burst_len = 0;
  end

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    words[addr[11:2]] = data;
  endtask

  // handshakes seen on the rising edge
  always @(posedge clock) begin
    ar_hs <= mem_ar.valid && ar_ready;
    r_hs <= mem_r.valid && r_ready;
    ar_addr_q <= mem_ar.addr;
    ar_len_q <= mem_ar.len;
  end

  always @(negedge clock) begin
    if (reset) begin
      ar_ready = 1'b0;
      mem_r = '0;
      busy = 1'b0;
    end else begin
      if (ar_hs) begin
        busy = 1'b1;
        burst_addr = ar_addr_q;
        // len counts beats minus one
        burst_len = int'(ar_len_q) + 1;
        beat = 0;
      end
      if (r_hs) begin
        beat = beat + 1;
        mem_r = '0;
        if (beat == burst_len) begin
          busy = 1'b0;
        end
      end
      if (busy) begin
        ar_ready = 1'b0;
      end else begin
        ar_ready = ($random(seed) & 1) != 0;
      end
      // random gaps between beats
      if (busy && !mem_r.valid && (($random(seed) & 3) != 0)) begin
        mem_r.valid = 1'b1;
        mem_r.data = words[burst_addr[11:2] + 10'(beat)];
        mem_r.last = (beat == burst_len - 1);
        mem_r.resp = 2'b00;
      end
    end
  end

endmodule

// File: test/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_tb
  import axi_pkg::*;
  import fetch_pkg::*;
;

  localparam int TOTAL_XFERS = 150;
  localparam int CYCLE_LIMIT = 40 * TOTAL_XFERS + 200;
  localparam logic [31:0] BASE = `FETCH_RESET_PC;

  logic clock;
  logic reset;
  redirect_t jump_redirect;
  redirect_t cs_redirect;
  logic fencei;
  logic out_ready;
  logic ar_ready;
  axi_r_t mem_r;
  logic out_valid;
  fetch_out_t out;
  axi_ar_t mem_ar;
  logic r_ready;

  integer seed;
  int errors;
  int test_errors_start;
  int tests_passed;
  int tests_failed;
  int transfers;
  int cycles;
  logic [31:0] exp_q [$];
  logic [31:0] exp_pc;
  logic [31:0] exp_inst;
  logic [31:0] last_inst;
  logic [31:0] new_word;

  fetch_top i_fetch_top (
    .clock         (clock),
    .reset         (reset),
    .jump_redirect (jump_redirect),
    .cs_redirect   (cs_redirect),
    .fencei        (fencei),
    .out_ready     (out_ready),
    .ar_ready      (ar_ready),
    .mem_r         (mem_r),
    .out_valid     (out_valid),
    .out           (out),
    .mem_ar        (mem_ar),
    .r_ready       (r_ready)
  );

  axi_mem_model mem (
    .clock    (clock),
    .reset    (reset),
    .mem_ar   (mem_ar),
    .ar_ready (ar_ready),
    .mem_r    (mem_r),
    .r_ready  (r_ready)
  );

  always #10 clock = ~clock;

  // static prediction, straight from the RV32 encodings
  function automatic logic [31:0] expected_next_pc(input logic [31:0] pc,
                                                   input logic [31:0] w);
    logic [31:0] off_b;
    logic [31:0] off_j;
    off_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    off_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    if (w[6:0] == 7'b1100011 && w[31]) begin
      return pc + off_b;
    end
    if (w[6:0] == 7'b1101111) begin
      return pc + off_j;
    end
    return pc + 32'd4;
  endfunction

  function automatic logic [31:0] branch_word(input logic [12:0] off);
    return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_word(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
  endfunction

  // op-imm words, differ for every address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:7] ^ addr[24:0], 7'b0010011};
  endfunction

  // comparator on accepted transfers
  always @(posedge clock) begin
    if (!reset && out_valid && out_ready) begin
      exp_pc = exp_q.pop_front();
      exp_inst = mem.words[exp_pc[11:2]];
      assert (out.pc == exp_pc) else begin
        $display("CHECK FAILED at %0t: pc %h, expected %h", $time, out.pc, exp_pc);
        errors++;
      end
      assert (out.inst == exp_inst) else begin
        $display("CHECK FAILED at %0t: inst %h, expected %h", $time, out.inst, exp_inst);
        errors++;
      end
      exp_q.push_back(expected_next_pc(exp_pc, exp_inst));
      last_inst <= out.inst;
      transfers++;
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run stopped after %0d cycles with %0d transfers", cycles, transfers);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic wait_transfers(input int n);
    int target;
    target = transfers + n;
    while (transfers < target) begin
      @(negedge clock);
    end
  endtask

  // one-cycle strobes, cs target wins when both are set
  task automatic send_redirect(input logic jump_en, input logic [31:0] jump_tgt,
                               input logic cs_en, input logic [31:0] cs_tgt,
                               input logic fence);
    jump_redirect = '{strobe: jump_en, target: jump_tgt};
    cs_redirect = '{strobe: cs_en, target: cs_tgt};
    fencei = fence;
    exp_q.delete();
    exp_q.push_back(cs_en ? cs_tgt : jump_tgt);
    @(negedge clock);
    jump_redirect = '0;
    cs_redirect = '0;
    fencei = 1'b0;
  endtask

  task automatic stall_randomly(input int n);
    int target;
    int stretch;
    target = transfers + n;
    stretch = 0;
    while (transfers < target) begin
      @(negedge clock);
      if (stretch == 0) begin
        out_ready = ($random(seed) & 1) != 0;
        stretch = 1 + ($random(seed) & 32'd5);
      end
      stretch--;
    end
    out_ready = 1'b1;
  endtask

  task automatic report_test(input string name);
    if (errors == test_errors_start) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: failed with %0d errors", name, errors - test_errors_start);
      tests_failed++;
    end
    test_errors_start = errors;
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    jump_redirect = '0;
    cs_redirect = '0;
    fencei = 1'b0;
    out_ready = 1'b1;
    seed = 32'hc88f_fafd;
    errors = 0;
    test_errors_start = 0;
    tests_passed = 0;
    tests_failed = 0;
    transfers = 0;
    cycles = 0;
    new_word = 32'h1234_5093;

    for (int i = 0; i < 1024; i++) begin
      mem.write_word(BASE + 32'(i * 4), fill_word(BASE + 32'(i * 4)));
    end
    // loop at 0x400: jal, forward branch, backward branch
    mem.write_word(BASE + 32'h400, jal_word(21'h20));
    mem.write_word(BASE + 32'h424, branch_word(13'h40));
    mem.write_word(BASE + 32'h428, branch_word(13'h1fdc));
    exp_q.push_back(BASE);

    repeat (2) @(negedge clock);
    reset = 1'b0;

    wait_transfers(40);
    report_test("sequential stream");

    send_redirect(1'b1, BASE + 32'h400, 1'b0, '0, 1'b0);
    wait_transfers(30);
    report_test("static prediction");

    send_redirect(1'b1, BASE + 32'h800, 1'b0, '0, 1'b0);
    wait_transfers(8);
    send_redirect(1'b0, '0, 1'b1, BASE + 32'h100, 1'b0);
    wait_transfers(8);
    send_redirect(1'b1, BASE + 32'h900, 1'b1, BASE + 32'ha00, 1'b0);
    wait_transfers(8);
    // catch a refill in flight
    while (!(mem_ar.valid || r_ready)) begin
      @(negedge clock);
    end
    send_redirect(1'b1, BASE + 32'hc00, 1'b0, '0, 1'b0);
    wait_transfers(8);
    report_test("redirects");

    send_redirect(1'b1, BASE + 32'h400, 1'b0, '0, 1'b0);
    stall_randomly(40);
    report_test("back-pressure");

    mem.write_word(BASE + 32'h404, new_word);
    send_redirect(1'b1, BASE + 32'h404, 1'b0, '0, 1'b1);
    wait_transfers(1);
    assert (last_inst == new_word) else begin
      $display("CHECK FAILED at %0t: inst after fence.i %h, expected %h", $time,
               last_inst, new_word);
      errors++;
    end
    wait_transfers(7);
    report_test("fence.i");

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+hdl
hdl/axi_pkg.sv
hdl/fetch_pkg.sv
hdl/icache.sv
hdl/next_pc_predict.sv
hdl/ifu.sv
hdl/fetch_top.sv
test/axi_mem_model.sv
test/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f tb.f \
  --top-module fetch_tb \
  -o fetch_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
